/* sim.f */
+incdir+tests
verilog/decode_pkg.sv
verilog/imm_gen.sv
verilog/opcode_decode.sv
verilog/funct_decode.sv
verilog/decode_stage.sv
tests/tb_decode.sv

/* run.sh */
#!/bin/sh
# compile and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_decode -f sim.f -o tb_decode_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_decode_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^RESULT: PASS$'; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tests/tb_encode.svh */
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

// expected decode bundle, one field per dut output
typedef struct packed {
    logic                  reg_w;
    logic                  mem_w;
    logic                  is_branch;
    logic                  is_ls;
    logic                  illegal;
    alu_op_e               alu_op;
    br_op_e                br_op;
    lis_op_e               lis_op;
    data_origin_e          origin;
    logic [strb_w-1:0]     strb;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
} bundle_t;

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

// s type, imm split around the rd slot
function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [6:0] opc);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};  // imm[0] dropped
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
endfunction

// sign extend the low w bits
function automatic logic [31:0] sext(logic [31:0] v, int w);
    return $signed(v << (32 - w)) >>> (32 - w);
endfunction

function automatic alu_op_e alu_expect(logic reg_form, logic [2:0] f3, logic b5);
    case (f3)
        3'd0:    return (reg_form && b5) ? alu_sub : alu_add;  // no subi
        3'd1:    return alu_sll;
        3'd2:    return alu_slt;
        3'd3:    return alu_sltu;
        3'd4:    return alu_xor;
        3'd5:    return b5 ? alu_sra : alu_srl;
        3'd6:    return alu_or;
        default: return alu_and;
    endcase
endfunction

// bit 2 splits eq/ne from the ordered compares, bit 0 inverts the sense
function automatic br_op_e branch_cmp_expect(logic [2:0] f3);
    if (!f3[2]) return f3[0] ? br_ne : br_eq;
    return f3[0] ? br_ge : br_lt;
endfunction

function automatic alu_op_e branch_alu_expect(logic [2:0] f3);
    if (!f3[2]) return alu_sub;
    return f3[1] ? alu_sltu : alu_slt;  // bit 1 marks the unsigned pair
endfunction

function automatic lis_op_e load_expect(logic [2:0] f3);
    case (f3)
        3'd1:    return lis_lh;
        3'd2:    return lis_lw;
        3'd4:    return lis_lbu;
        3'd5:    return lis_lhu;
        default: return lis_lb;
    endcase
endfunction

function automatic lis_op_e store_expect(logic [2:0] f3);
    case (f3)
        3'd1:    return lis_sh;
        3'd2:    return lis_sw;
        default: return lis_sb;
    endcase
endfunction

// 1, 2 or 4 lanes from the low end
function automatic logic [strb_w-1:0] store_mask(logic [2:0] f3);
    return strb_w'((32'd1 << (32'd1 << f3)) - 32'd1);
endfunction

function automatic logic is_known_opcode(logic [6:0] opc);
    return opc inside {opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch, opc_load,
                       opc_store, opc_op_imm, opc_op, opc_fence, opc_system};
endfunction

`endif

/* tests/tb_decode.sv */
`timescale 1ns/1ps

module tb_decode import decode_pkg::*; ();

    logic                  clk_i;
    logic                  reset_i;
    logic                  instr_valid_i;
    logic [xlen-1:0]       instr_i;
    logic                  valid_o;
    logic                  reg_w_o;
    logic                  mem_w_o;
    logic                  is_branch_o;
    logic                  is_load_store_o;
    logic                  illegal_o;
    alu_op_e               alu_op_o;
    br_op_e                br_op_o;
    lis_op_e               lis_op_o;
    data_origin_e          data_origin_o;
    logic [strb_w-1:0]     write_strb_o;
    logic [xlen-1:0]       imm_o;
    logic [reg_addr_w-1:0] rs1_addr_o;
    logic [reg_addr_w-1:0] rs2_addr_o;
    logic [reg_addr_w-1:0] rd_addr_o;

    `include "tb_encode.svh"

    int          num_instr = 600;
    logic [31:0] lfsr_state = 32'h3ebe;
    bundle_t     cur_exp;            // expected bundle for the word on instr_i
    bundle_t     exp_q;              // lined up with the dut outputs
    logic        exp_valid_q;
    logic        rst_seen_q = 1'b0;  // reset was sampled on the previous edge
    logic [9:0]  ctrl_bits;
    logic [9:0]  exp_ctrl;

    decode_stage i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] bits;
        logic        fb;
        int          k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("CHECK FAILED: %s got %h expected %h", name, got, want);
        $display("RESULT: FAIL");
        $fatal(1, "decode output mismatch");
    endtask

    // random legal word of a random kind, plus what the decoder should make of it
    task automatic build_instr(output logic [31:0] word, output bundle_t e);
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] r;    // raw immediate and filler bits
        logic [11:0] i12;
        logic        b5;
        logic [6:0]  opc;
        kind = 4'(take_bits(4));
        rs1  = 5'(take_bits(5));
        rs2  = 5'(take_bits(5));
        rd   = 5'(take_bits(5));
        r    = take_bits(32);
        f3   = 3'(take_bits(3));
        i12  = r[11:0];
        e    = '0;
        case (kind)
            4'd0, 4'd12: begin  // op, bit 30 only legal for add/sub and srl/sra
                b5 = (f3 == 3'd0 || f3 == 3'd5) ? 1'(take_bits(1)) : 1'b0;
                word     = enc_r({1'b0, b5, 5'd0}, rs2, rs1, f3, rd, opc_op);
                e.reg_w  = 1'b1;
                e.alu_op = alu_expect(1'b1, f3, b5);
                e.rs1    = rs1;
                e.rs2    = rs2;
                e.rd     = rd;
            end
            4'd1, 4'd13: begin  // op-imm, shifts carry funct7 in the imm
                if (f3 == 3'd1) i12[11:5] = 7'd0;
                if (f3 == 3'd5) i12[11:5] = {1'b0, r[10], 5'd0};
                word     = enc_i(i12, rs1, f3, rd, opc_op_imm);
                e.reg_w  = 1'b1;
                e.alu_op = alu_expect(1'b0, f3, i12[10]);
                e.origin = rs2imm_rs1;
                e.imm    = sext(32'(i12), 12);
                e.rs1    = rs1;
                e.rd     = rd;
            end
            4'd2, 4'd14: begin
                if (f3 == 3'd3 || f3 >= 3'd6) f3 = f3 & 3'b010;  // reserved -> lw
                word     = enc_i(i12, rs1, f3, rd, opc_load);
                e.reg_w  = 1'b1;
                e.is_ls  = 1'b1;
                e.lis_op = load_expect(f3);
                e.origin = rs2imm_rs1;
                e.imm    = sext(32'(i12), 12);
                e.rs1    = rs1;
                e.rd     = rd;
            end
            4'd3, 4'd15: begin
                f3       = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
                word     = enc_s(i12, rs2, rs1, f3, opc_store);
                e.mem_w  = 1'b1;
                e.is_ls  = 1'b1;
                e.lis_op = store_expect(f3);
                e.strb   = store_mask(f3);
                e.origin = rs2imm_rs1;
                e.imm    = sext(32'(i12), 12);
                e.rs1    = rs1;
                e.rs2    = rs2;
            end
            4'd4: begin
                if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 | 3'b100;
                word        = enc_b({i12, 1'b0}, rs2, rs1, f3, opc_branch);
                e.is_branch = 1'b1;
                e.alu_op    = branch_alu_expect(f3);
                e.br_op     = branch_cmp_expect(f3);
                e.imm       = sext(32'({i12, 1'b0}), 13);
                e.rs1       = rs1;
                e.rs2       = rs2;
            end
            4'd5, 4'd6: begin  // lui adds to x0, auipc to the pc
                word     = enc_u(r[19:0], rd, (kind == 4'd5) ? opc_lui : opc_auipc);
                e.reg_w  = 1'b1;
                e.origin = (kind == 4'd5) ? rs2imm_rs1 : rs2imm_rs1pc;
                e.imm    = {r[19:0], 12'd0};
                e.rd     = rd;
            end
            4'd7: begin
                word        = enc_j({r[19:0], 1'b0}, rd, opc_jal);
                e.reg_w     = 1'b1;
                e.is_branch = 1'b1;
                e.origin    = rs2imm_rs1pc;
                e.imm       = sext(32'({r[19:0], 1'b0}), 21);
                e.rd        = rd;
            end
            4'd8: begin
                word        = enc_i(i12, rs1, 3'd0, rd, opc_jalr);
                e.reg_w     = 1'b1;
                e.is_branch = 1'b1;
                e.origin    = rs2imm_rs1;
                e.imm       = sext(32'(i12), 12);
                e.rs1       = rs1;
                e.rd        = rd;
            end
            4'd9: word = {r[31:7], opc_fence};  // nop, nothing set
            4'd10: begin
                word      = {r[31:7], opc_system};
                e.illegal = 1'b1;
            end
            default: begin  // opcode outside rv32i
                opc = 7'(take_bits(7));
                while (is_known_opcode(opc)) opc = 7'(take_bits(7));
                word      = {r[31:7], opc};
                e.illegal = 1'b1;
            end
        endcase
    endtask

    // expectation pipeline, one deep like the dut
    always @(posedge clk_i) begin
        rst_seen_q <= reset_i;
        if (reset_i) begin
            exp_valid_q <= 1'b0;
        end else begin
            exp_valid_q <= instr_valid_i;
        end
        if (instr_valid_i) exp_q <= cur_exp;
    end

    assign ctrl_bits = {valid_o, reg_w_o, mem_w_o, is_branch_o, is_load_store_o, illegal_o,
                        write_strb_o};
    assign exp_ctrl  = {1'b1, exp_q.reg_w, exp_q.mem_w, exp_q.is_branch, exp_q.is_ls,
                        exp_q.illegal, exp_q.strb};

    assert property (@(posedge clk_i) rst_seen_q |-> ctrl_bits == '0)
        else report_mismatch("ctrl_bits after reset", 32'(ctrl_bits), 32'd0);
    assert property (@(posedge clk_i) disable iff (reset_i) valid_o == exp_valid_q)
        else report_mismatch("valid_o", 32'(valid_o), 32'(exp_valid_q));
    assert property (@(posedge clk_i) disable iff (reset_i) !valid_o |-> ctrl_bits == '0)
        else report_mismatch("ctrl_bits on bubble", 32'(ctrl_bits), 32'd0);
    // valid, reg_w, mem_w, is_branch, is_load_store, illegal, write_strb
    assert property (@(posedge clk_i) disable iff (reset_i) valid_o |-> ctrl_bits == exp_ctrl)
        else report_mismatch("ctrl_bits", 32'(ctrl_bits), 32'(exp_ctrl));
    assert property (@(posedge clk_i) disable iff (reset_i) valid_o |-> alu_op_o == exp_q.alu_op)
        else report_mismatch("alu_op_o", 32'(alu_op_o), 32'(exp_q.alu_op));
    assert property (@(posedge clk_i) disable iff (reset_i) valid_o |-> br_op_o == exp_q.br_op)
        else report_mismatch("br_op_o", 32'(br_op_o), 32'(exp_q.br_op));
    assert property (@(posedge clk_i) disable iff (reset_i) valid_o |-> lis_op_o == exp_q.lis_op)
        else report_mismatch("lis_op_o", 32'(lis_op_o), 32'(exp_q.lis_op));
    assert property (@(posedge clk_i) disable iff (reset_i)
                     valid_o |-> data_origin_o == exp_q.origin)
        else report_mismatch("data_origin_o", 32'(data_origin_o), 32'(exp_q.origin));
    assert property (@(posedge clk_i) disable iff (reset_i) valid_o |-> imm_o == exp_q.imm)
        else report_mismatch("imm_o", imm_o, exp_q.imm);
    assert property (@(posedge clk_i) disable iff (reset_i) valid_o |-> rs1_addr_o == exp_q.rs1)
        else report_mismatch("rs1_addr_o", 32'(rs1_addr_o), 32'(exp_q.rs1));
    assert property (@(posedge clk_i) disable iff (reset_i) valid_o |-> rs2_addr_o == exp_q.rs2)
        else report_mismatch("rs2_addr_o", 32'(rs2_addr_o), 32'(exp_q.rs2));
    assert property (@(posedge clk_i) disable iff (reset_i) valid_o |-> rd_addr_o == exp_q.rd)
        else report_mismatch("rd_addr_o", 32'(rd_addr_o), 32'(exp_q.rd));

    initial begin
        logic [31:0] word;
        bundle_t     e;
        int          n;
        reset_i       = 1'b1;
        instr_valid_i = 1'b1;  // reset has to win over a valid store word
        instr_i       = enc_s(12'h7f0, 5'd3, 5'd2, 3'd2, opc_store);
        cur_exp       = '0;
        repeat (2) @(posedge clk_i);
        reset_i       <= 1'b0;
        instr_valid_i <= 1'b0;
        for (n = 0; n < num_instr; n++) begin
            @(posedge clk_i);
            build_instr(word, e);
            instr_i       <= word;
            instr_valid_i <= (take_bits(2) != 32'd0);  // about one bubble in four
            cur_exp       <= e;
        end
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        repeat (3) @(posedge clk_i);  // drain the last bundle through the checks
        $display("RESULT: PASS");
        $finish;
    end

    // reset, stream and drain plus a margin
    initial begin
        #((num_instr + 50) * 8);
        $display("timeout: the run did not finish in %0d cycles", num_instr + 50);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* verilog/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic                  instr_valid_i,
    input  wire logic [xlen-1:0]       instr_i,
    output logic                       valid_o,
    output logic                       reg_w_o,
    output logic                       mem_w_o,
    output logic                       is_branch_o,
    output logic                       is_load_store_o,
    output logic                       illegal_o,
    output alu_op_e                    alu_op_o,
    output br_op_e                     br_op_o,
    output lis_op_e                    lis_op_o,
    output data_origin_e               data_origin_o,
    output logic [strb_w-1:0]          write_strb_o,
    output logic [xlen-1:0]            imm_o,
    output logic [reg_addr_w-1:0]      rs1_addr_o,
    output logic [reg_addr_w-1:0]      rs2_addr_o,
    output logic [reg_addr_w-1:0]      rd_addr_o
);

    instr_class_e          dec_class;
    imm_fmt_e              dec_imm_fmt;
    data_origin_e          dec_origin;
    logic                  dec_reg_w;
    logic                  dec_mem_w;
    logic                  dec_branch;
    logic                  dec_ls;
    logic                  dec_illegal;
    logic [reg_addr_w-1:0] dec_rs1;
    logic [reg_addr_w-1:0] dec_rs2;
    logic [reg_addr_w-1:0] dec_rd;
    alu_op_e               dec_alu_op;
    br_op_e                dec_br_op;
    lis_op_e               dec_lis_op;
    logic [strb_w-1:0]     dec_strb;
    logic [xlen-1:0]       dec_imm;

    opcode_decode i_opcode_decode (
        .instr_i        (instr_i),
        .class_o        (dec_class),
        .imm_fmt_o      (dec_imm_fmt),
        .data_origin_o  (dec_origin),
        .reg_w_o        (dec_reg_w),
        .mem_w_o        (dec_mem_w),
        .is_branch_o    (dec_branch),
        .is_load_store_o(dec_ls),
        .illegal_o      (dec_illegal),
        .rs1_addr_o     (dec_rs1),
        .rs2_addr_o     (dec_rs2),
        .rd_addr_o      (dec_rd)
    );

    funct_decode i_funct_decode (
        .class_i     (dec_class),
        .funct3_i    (instr_i[14:12]),
        .funct7_b5_i (instr_i[30]),
        .alu_op_o    (dec_alu_op),
        .br_op_o     (dec_br_op),
        .lis_op_o    (dec_lis_op),
        .write_strb_o(dec_strb)
    );

    imm_gen i_imm_gen (
        .instr_i  (instr_i),
        .imm_fmt_i(dec_imm_fmt),
        .imm_o    (dec_imm)
    );

    // control flags: cleared on reset, forced low on bubbles
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o         <= 1'b0;
            reg_w_o         <= 1'b0;
            mem_w_o         <= 1'b0;
            is_branch_o     <= 1'b0;
            is_load_store_o <= 1'b0;
            illegal_o       <= 1'b0;
            write_strb_o    <= '0;
        end else begin
            valid_o         <= instr_valid_i;
            reg_w_o         <= instr_valid_i & dec_reg_w;
            mem_w_o         <= instr_valid_i & dec_mem_w;
            is_branch_o     <= instr_valid_i & dec_branch;
            is_load_store_o <= instr_valid_i & dec_ls;
            illegal_o       <= instr_valid_i & dec_illegal;
            write_strb_o    <= instr_valid_i ? dec_strb : '0;
        end
    end

    // payload only moves with a valid instruction, holds otherwise
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            alu_op_o      <= dec_alu_op;
            br_op_o       <= dec_br_op;
            lis_op_o      <= dec_lis_op;
            data_origin_o <= dec_origin;
            imm_o         <= dec_imm;
            rs1_addr_o    <= dec_rs1;
            rs2_addr_o    <= dec_rs2;
            rd_addr_o     <= dec_rd;
        end
    end

    // a store never also writes the register file
    assert property (@(posedge clk_i) disable iff (reset_i) !(mem_w_o && reg_w_o))
        else $error("decode_stage: mem_w and reg_w both set");

    // byte lanes from funct_decode must line up with the opcode side mem_w
    assert property (@(posedge clk_i) disable iff (reset_i) (write_strb_o != '0) |-> mem_w_o)
        else $error("decode_stage: write strobe without mem_w");

endmodule

`default_nettype wire

/* verilog/funct_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module funct_decode import decode_pkg::*; (
    input  wire instr_class_e     class_i,
    input  wire logic [2:0]       funct3_i,
    input  wire logic             funct7_b5_i,  // instr[30], sub / sra select
    output alu_op_e               alu_op_o,
    output br_op_e                br_op_o,
    output lis_op_e               lis_op_o,
    output logic [strb_w-1:0]     write_strb_o
);

    always_comb begin
        alu_op_o     = alu_add;  // address / pc arithmetic by default
        br_op_o      = br_eq;
        lis_op_o     = lis_lb;
        write_strb_o = '0;

        case (class_i)
            cls_alu_imm, cls_alu_reg: begin
                case (funct3_i)
                    3'b000: begin
                        // the immediate form has no subi, bit 30 is part of the imm
                        if (class_i == cls_alu_reg && funct7_b5_i) begin
                            alu_op_o = alu_sub;
                        end else begin
                            alu_op_o = alu_add;
                        end
                    end
                    3'b001: alu_op_o = alu_sll;
                    3'b010: alu_op_o = alu_slt;
                    3'b011: alu_op_o = alu_sltu;
                    3'b100: alu_op_o = alu_xor;
                    3'b101: alu_op_o = funct7_b5_i ? alu_sra : alu_srl;  // srai keeps bit 30
                    3'b110: alu_op_o = alu_or;
                    default: alu_op_o = alu_and;
                endcase
            end
            cls_branch: begin
                case (funct3_i)
                    3'b000: begin  // beq
                        alu_op_o = alu_sub;
                        br_op_o  = br_eq;
                    end
                    3'b001: begin  // bne
                        alu_op_o = alu_sub;
                        br_op_o  = br_ne;
                    end
                    3'b100: begin  // blt
                        alu_op_o = alu_slt;
                        br_op_o  = br_lt;
                    end
                    3'b101: begin  // bge
                        alu_op_o = alu_slt;
                        br_op_o  = br_ge;
                    end
                    3'b110: begin  // bltu
                        alu_op_o = alu_sltu;
                        br_op_o  = br_lt;
                    end
                    3'b111: begin  // bgeu
                        alu_op_o = alu_sltu;
                        br_op_o  = br_ge;
                    end
                    default: begin
                        alu_op_o = alu_sub;  // reserved funct3, treat as beq
                    end
                endcase
            end
            cls_load: begin
                case (funct3_i)
                    3'b001:  lis_op_o = lis_lh;
                    3'b010:  lis_op_o = lis_lw;
                    3'b100:  lis_op_o = lis_lbu;
                    3'b101:  lis_op_o = lis_lhu;
                    default: lis_op_o = lis_lb;
                endcase
            end
            cls_store: begin
                case (funct3_i)
                    3'b001: begin
                        lis_op_o     = lis_sh;
                        write_strb_o = strb_half;
                    end
                    3'b010: begin
                        lis_op_o     = lis_sw;
                        write_strb_o = strb_word;
                    end
                    default: begin
                        lis_op_o     = lis_sb;
                        write_strb_o = strb_byte;
                    end
                endcase
            end
            default: begin
                // upper/jump and none keep the add default
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/opcode_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module opcode_decode import decode_pkg::*; (
    input  wire logic [xlen-1:0] instr_i,
    output instr_class_e         class_o,
    output imm_fmt_e             imm_fmt_o,
    output data_origin_e         data_origin_o,
    output logic                 reg_w_o,
    output logic                 mem_w_o,
    output logic                 is_branch_o,
    output logic                 is_load_store_o,
    output logic                 illegal_o,
    output logic [reg_addr_w-1:0] rs1_addr_o,
    output logic [reg_addr_w-1:0] rs2_addr_o,
    output logic [reg_addr_w-1:0] rd_addr_o
);

    opcode_e               opcode;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    always_comb begin
        // everything inactive unless the opcode says otherwise
        class_o         = cls_none;
        imm_fmt_o       = imm_none;
        data_origin_o   = regs;
        reg_w_o         = 1'b0;
        mem_w_o         = 1'b0;
        is_branch_o     = 1'b0;
        is_load_store_o = 1'b0;
        illegal_o       = 1'b0;
        rs1_addr_o      = '0;  // unused addresses read as x0
        rs2_addr_o      = '0;
        rd_addr_o       = '0;

        case (opcode)
            opc_lui: begin  // rd = imm + x0
                class_o       = cls_upper_jump;
                imm_fmt_o     = imm_u;
                data_origin_o = rs2imm_rs1;  // rs1 forced to x0
                reg_w_o       = 1'b1;
                rd_addr_o     = rd;
            end
            opc_auipc: begin  // rd = pc + imm
                class_o       = cls_upper_jump;
                imm_fmt_o     = imm_u;
                data_origin_o = rs2imm_rs1pc;
                reg_w_o       = 1'b1;
                rd_addr_o     = rd;
            end
            opc_jal: begin
                class_o       = cls_upper_jump;
                imm_fmt_o     = imm_j;
                data_origin_o = rs2imm_rs1pc;  // target is pc relative
                is_branch_o   = 1'b1;
                reg_w_o       = 1'b1;  // link pc+4
                rd_addr_o     = rd;
            end
            opc_jalr: begin
                class_o       = cls_upper_jump;
                imm_fmt_o     = imm_i;
                data_origin_o = rs2imm_rs1;  // target is rs1 + imm
                is_branch_o   = 1'b1;
                reg_w_o       = 1'b1;
                rs1_addr_o    = rs1;
                rd_addr_o     = rd;
            end
            opc_branch: begin
                class_o     = cls_branch;
                imm_fmt_o   = imm_b;
                is_branch_o = 1'b1;  // compare on regs, target from imm
                rs1_addr_o  = rs1;
                rs2_addr_o  = rs2;
            end
            opc_load: begin
                class_o         = cls_load;
                imm_fmt_o       = imm_i;
                data_origin_o   = rs2imm_rs1;  // address = rs1 + imm
                is_load_store_o = 1'b1;
                reg_w_o         = 1'b1;
                rs1_addr_o      = rs1;
                rd_addr_o       = rd;
            end
            opc_store: begin
                class_o         = cls_store;
                imm_fmt_o       = imm_s;
                data_origin_o   = rs2imm_rs1;
                is_load_store_o = 1'b1;
                mem_w_o         = 1'b1;
                rs1_addr_o      = rs1;  // base
                rs2_addr_o      = rs2;  // store data
            end
            opc_op_imm: begin
                class_o       = cls_alu_imm;
                imm_fmt_o     = imm_i;
                data_origin_o = rs2imm_rs1;
                reg_w_o       = 1'b1;
                rs1_addr_o    = rs1;
                rd_addr_o     = rd;
            end
            opc_op: begin
                class_o    = cls_alu_reg;
                reg_w_o    = 1'b1;
                rs1_addr_o = rs1;
                rs2_addr_o = rs2;
                rd_addr_o  = rd;
            end
            opc_fence: begin
                // single hart, in-order memory, nothing to do
            end
            opc_system: begin
                illegal_o = 1'b1;  // csr and ecall/ebreak not implemented
            end
            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/imm_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module imm_gen import decode_pkg::*; (
    input  wire logic [xlen-1:0] instr_i,
    input  wire imm_fmt_e        imm_fmt_i,
    output logic [xlen-1:0]      imm_o
);

    logic        sign;      // every rv32i immediate is signed from bit 31
    logic [11:0] imm12_i;   // loads, op-imm, jalr
    logic [11:0] imm12_s;   // stores, split around rd slot
    logic [11:0] imm12_b;   // branches, bit 0 implied zero
    logic [19:0] imm20_u;   // lui, auipc
    logic [19:0] imm20_j;   // jal, bit 0 implied zero

    assign sign = instr_i[xlen-1];

    assign imm12_i = instr_i[31:20];
    assign imm12_s = {instr_i[31:25], instr_i[11:7]};
    assign imm12_b = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8]};  // imm[12:1]
    assign imm20_u = instr_i[31:12];
    assign imm20_j = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21]};  // imm[20:1]

    always_comb begin
        case (imm_fmt_i)
            imm_i: begin
                imm_o = {{(xlen-12){sign}}, imm12_i};
            end
            imm_s: begin
                imm_o = {{(xlen-12){sign}}, imm12_s};
            end
            imm_b: begin
                imm_o = {{(xlen-13){sign}}, imm12_b, 1'b0};  // halfword aligned target
            end
            imm_u: begin
                imm_o = {imm20_u, 12'd0};  // upper 20 bits, low part zero
            end
            imm_j: begin
                imm_o = {{(xlen-21){sign}}, imm20_j, 1'b0};
            end
            default: begin
                imm_o = '0;  // op, fence, illegal
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    localparam int xlen       = 32;  // instruction and data width
    localparam int reg_addr_w = 5;   // x0..x31
    localparam int strb_w     = 4;   // one bit per byte lane

    // store byte lane masks
    localparam logic [strb_w-1:0] strb_byte = 4'b0001;
    localparam logic [strb_w-1:0] strb_half = 4'b0011;
    localparam logic [strb_w-1:0] strb_word = 4'b1111;

    // rv32i major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_fence  = 7'b0001111,
        opc_system = 7'b1110011  // no csr support here, decodes illegal
    } opcode_e;

    // coarse class handed from the opcode decoder to the funct decoder
    typedef enum logic [2:0] {
        cls_none,
        cls_alu_imm,
        cls_alu_reg,
        cls_branch,
        cls_load,
        cls_store,
        cls_upper_jump  // lui, auipc, jal, jalr
    } instr_class_e;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_e;

    typedef enum logic [3:0] {
        alu_add = 4'd0,  // also address and pc arithmetic
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // signedness of lt/ge comes from alu_op (slt vs sltu)
    typedef enum logic [1:0] {
        br_eq = 2'd0,
        br_ne,
        br_lt,
        br_ge
    } br_op_e;

    typedef enum logic [2:0] {
        lis_lb = 3'd0,
        lis_lh,
        lis_lw,
        lis_lbu,
        lis_lhu,
        lis_sb,
        lis_sh,
        lis_sw
    } lis_op_e;

    // which operands the execution unit uses
    typedef enum logic [1:0] {
        regs         = 2'd0,  // rs1, rs2
        rs2imm_rs1   = 2'd1,  // rs1, imm
        rs2imm_rs1pc = 2'd2   // pc, imm
    } data_origin_e;

endpackage

`default_nettype wire
